/* rtl/vid_cfg.svh */
// Tile map geometry and video RAM address width macros
`ifndef VID_CFG_SVH
`define VID_CFG_SVH

// ----------------------------------------
// Tile map geometry
// ----------------------------------------

// Tiles per row, also the scanline buffer depth
`define VID_COLS 32

// Tile rows in the map
`define VID_ROWS 32

// ----------------------------------------
// Address widths
// ----------------------------------------

// CPU side, one byte per address
`define VID_BYTE_AW 11

// Video side, one 16-bit tile word per address
`define VID_WORD_AW 10

`endif

/* rtl/vidMemPkg.sv */
// Memory word types: address types, tile word union and line buffer entry
`include "vid_cfg.svh"

package vidMemPkg;

	// CPU byte address and video word address
	typedef logic [`VID_BYTE_AW-1:0] byteAddr;
	typedef logic [`VID_WORD_AW-1:0] wordAddr;

	// ----------------------------------------
	// Tile word as read from the two banks
	// ----------------------------------------
	typedef union packed {
		// Raw bytes, odd bank high and even bank low
		struct packed {
			logic [7:0] hi;
			logic [7:0] lo;
		} bytes;
		// Decoded tile fields
		struct packed {
			logic [7:0] attr;
			logic [7:0] code;
		} tile;
	} vramWord;

	// Scanline buffer entry, 11 bits
	typedef struct packed {
		logic [2:0] palette;
		logic [7:0] code;
	} lineEntry;

endpackage

/* rtl/vidCtrlPkg.sv */
// Control types: fetch state enum and column index
`include "vid_cfg.svh"

package vidCtrlPkg;

	// ----------------------------------------
	// Line fetch sequencer states
	// ----------------------------------------
	typedef enum logic [1:0] {
		Idle,
		Fetch,
		Drain
	} fetchState;

	// Column within a tile row
	typedef logic [$clog2(`VID_COLS)-1:0] colIdx;

endpackage

/* rtl/lineBufIf.sv */
// Scanline buffer interface with writer, reader and buffer modports
`timescale 1ns/1ps

interface lineBufIf;
	import vidMemPkg::*;
	import vidCtrlPkg::*;

	// Write side, driven by the fetch sequencer
	colIdx wrAddr;
	lineEntry wrData;
	logic wrEn;

	// Display read side
	colIdx rdAddr;
	logic rdEn;
	lineEntry rdData;

	modport writer (output wrAddr, output wrData, output wrEn);

	modport reader (output rdAddr, output rdEn, input rdData);

	modport buffer (input wrAddr, input wrData, input wrEn,
		input rdAddr, input rdEn, output rdData);

endinterface

/* rtl/apbVram.sv */
// APB slave video RAM with even and odd byte banks and a 16-bit video port
`timescale 1ns/1ps
`include "vid_cfg.svh"

module apbVram (
	input  logic               clk0,
	input  logic               arstN,
	input  logic               psel,
	input  logic               penable,
	input  logic               pwrite,
	input  vidMemPkg::byteAddr paddr,
	input  logic [7:0]         pwdata,
	output logic [7:0]         prdata,
	output logic               pready,
	input  vidMemPkg::wordAddr vidAddr,
	output vidMemPkg::vramWord vidData
);
	import vidMemPkg::*;

	localparam int bankDepth = 2 ** `VID_WORD_AW;

	logic [7:0] evenBank [bankDepth];
	logic [7:0] oddBank [bankDepth];

	wordAddr cpuWord;
	logic access;
	logic wrAcc;
	logic rdFirst;
	logic rdWait;
	logic [7:0] evenQ;
	logic [7:0] oddQ;
	logic oddSel;

	// ----------------------------------------
	// APB phase decode
	// ----------------------------------------
	assign access = psel & penable;
	assign wrAcc = access & pwrite;
	// First access cycle of a read, the wait state
	assign rdFirst = access & ~pwrite & ~rdWait;
	assign cpuWord = paddr[`VID_BYTE_AW-1:1];

	// Writes finish at once, reads one cycle later
	assign pready = access & (pwrite | rdWait);

	always_ff @(posedge clk0 or negedge arstN) begin
		if (!arstN) begin
			rdWait <= 1'b0;
		end else begin
			rdWait <= rdFirst;
		end
	end

	// Byte lane steering by address bit 0
	always_ff @(posedge clk0) begin
		if (wrAcc && !paddr[0])
			evenBank[cpuWord] <= pwdata;
		if (wrAcc && paddr[0])
			oddBank[cpuWord] <= pwdata;
	end

	// CPU read during the wait state
	always_ff @(posedge clk0) begin
		if (rdFirst) begin
			evenQ <= evenBank[cpuWord];
			oddQ <= oddBank[cpuWord];
			oddSel <= paddr[0];
		end
	end

	assign prdata = oddSel ? oddQ : evenQ;

	// ----------------------------------------
	// Video port, both banks in one cycle
	// ----------------------------------------
	always_ff @(posedge clk0) begin
		vidData.bytes.lo <= evenBank[vidAddr];
		vidData.bytes.hi <= oddBank[vidAddr];
	end

endmodule

/* rtl/lineFetchSeq.sv */
// Line fetch FSM: reads one tile row and writes decoded entries to the line buffer
`timescale 1ns/1ps
`include "vid_cfg.svh"

module lineFetchSeq (
	input  logic                         clk0,
	input  logic                         arstN,
	input  logic                         lineStart,
	input  logic [$clog2(`VID_ROWS)-1:0] lineRow,
	output logic                         lineBusy,
	output logic                         lineDone,
	output vidMemPkg::wordAddr           vidAddr,
	input  vidMemPkg::vramWord           vidData,
	output logic                         cntClr,
	output logic                         cntEn,
	input  vidCtrlPkg::colIdx            col,
	input  logic                         lastCol,
	lineBufIf.writer                     bufPort
);
	import vidMemPkg::*;
	import vidCtrlPkg::*;

	fetchState state;
	logic [$clog2(`VID_ROWS)-1:0] rowReg;
	colIdx colPipe;
	logic pipeValid;
	logic startOk;
	lineEntry entry;

	// Start is ignored while a line is in progress
	assign startOk = (state == Idle) && lineStart && !lineBusy;

	assign cntClr = (state == Idle);
	assign cntEn = (state == Fetch);
	assign vidAddr = {rowReg, col};

	// Hidden tiles become an all-zero entry
	always_comb begin
		entry = '0;
		if (!vidData.tile.attr[7]) begin
			entry.palette = vidData.tile.attr[2:0];
			entry.code = vidData.tile.code;
		end
	end

	// Write one cycle behind the address
	assign bufPort.wrEn = pipeValid;
	assign bufPort.wrAddr = colPipe;
	assign bufPort.wrData = entry;

	always_ff @(posedge clk0) begin
		if (startOk)
			rowReg <= lineRow;
		colPipe <= col;
	end

	always_ff @(posedge clk0 or negedge arstN) begin
		if (!arstN) begin
			state <= Idle;
			pipeValid <= 1'b0;
			lineBusy <= 1'b0;
			lineDone <= 1'b0;
		end else begin
			pipeValid <= (state == Fetch);
			lineDone <= 1'b0;
			// Busy falls after the done cycle
			if (lineDone)
				lineBusy <= 1'b0;
			case (state)
				Idle: begin
					if (startOk) begin
						state <= Fetch;
						lineBusy <= 1'b1;
					end
				end
				Fetch: begin
					if (lastCol)
						state <= Drain;
				end
				Drain: begin
					state <= Idle;
					lineDone <= 1'b1;
				end
				default: state <= Idle;
			endcase
		end
	end

endmodule

/* rtl/columnCounter.sv */
// Column counter with clear, enable and last-column flag
`timescale 1ns/1ps
`include "vid_cfg.svh"

module columnCounter (
	input  logic              clk0,
	input  logic              arstN,
	input  logic              cntClr,
	input  logic              cntEn,
	output vidCtrlPkg::colIdx col,
	output logic              lastCol
);
	import vidCtrlPkg::*;

	localparam colIdx maxCol = colIdx'(`VID_COLS - 1);

	assign lastCol = (col == maxCol);

	// Clear wins over count
	always_ff @(posedge clk0 or negedge arstN) begin
		if (!arstN) begin
			col <= '0;
		end else if (cntClr) begin
			col <= '0;
		end else if (cntEn) begin
			if (lastCol)
				col <= '0;
			else
				col <= col + 1'b1;
		end
	end

endmodule

/* rtl/lineBuffer.sv */
// Scanline buffer with a write port and a clear-on-read display port
`timescale 1ns/1ps
`include "vid_cfg.svh"

module lineBuffer (
	input  logic       clk0,
	lineBufIf.buffer   port
);
	import vidMemPkg::*;

	lineEntry mem [`VID_COLS];

	// ----------------------------------------
	// Read and clear, then write
	// ----------------------------------------
	always_ff @(posedge clk0) begin
		if (port.rdEn) begin
			port.rdData <= mem[port.rdAddr];
			// Stale tiles must not show on a later line
			mem[port.rdAddr] <= '0;
		end
		// Fetch write takes the location if both hit
		if (port.wrEn)
			mem[port.wrAddr] <= port.wrData;
	end

endmodule

/* rtl/vidMemTop.sv */
// Tile map memory top: video RAM, fetch FSM, column counter and scanline buffer
`timescale 1ns/1ps
`include "vid_cfg.svh"

module vidMemTop (
	input  logic                         clk0,
	input  logic                         arstN,
	input  logic                         psel,
	input  logic                         penable,
	input  logic                         pwrite,
	input  vidMemPkg::byteAddr           paddr,
	input  logic [7:0]                   pwdata,
	output logic [7:0]                   prdata,
	output logic                         pready,
	input  logic                         lineStart,
	input  logic [$clog2(`VID_ROWS)-1:0] lineRow,
	output logic                         lineBusy,
	output logic                         lineDone,
	input  vidCtrlPkg::colIdx            colAddr,
	input  logic                         colRd,
	output vidMemPkg::lineEntry          colData
);
	import vidMemPkg::*;
	import vidCtrlPkg::*;

	wordAddr vidAddr;
	vramWord vidData;
	colIdx col;
	logic cntClr;
	logic cntEn;
	logic lastCol;

	lineBufIf lineIf ();

	// Display side of the buffer
	assign lineIf.rdAddr = colAddr;
	assign lineIf.rdEn = colRd;
	assign colData = lineIf.rdData;

	apbVram vram_i (.clk0(clk0), .arstN(arstN), .psel(psel), .penable(penable),
		.pwrite(pwrite), .paddr(paddr), .pwdata(pwdata), .prdata(prdata),
		.pready(pready), .vidAddr(vidAddr), .vidData(vidData));

	lineFetchSeq seq_i (.clk0(clk0), .arstN(arstN), .lineStart(lineStart),
		.lineRow(lineRow), .lineBusy(lineBusy), .lineDone(lineDone),
		.vidAddr(vidAddr), .vidData(vidData), .cntClr(cntClr), .cntEn(cntEn),
		.col(col), .lastCol(lastCol), .bufPort(lineIf.writer));

	columnCounter cnt_i (.clk0(clk0), .arstN(arstN), .cntClr(cntClr),
		.cntEn(cntEn), .col(col), .lastCol(lastCol));

	lineBuffer lbuf_i (.clk0(clk0), .port(lineIf.buffer));

endmodule

/* sim/vidMem_assertions.sv */
// APB and line fetch timing assertions, bound into the video RAM and the fetch FSM
`timescale 1ns/1ps

module vidMemAssertions (
	input logic clk0,
	input logic arstN,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic pready,
	input logic lineStart,
	input logic lineBusy,
	input logic lineDone
);
	// Writes complete in the first access cycle
	writeNoWait: assert property (@(posedge clk0) disable iff (!arstN)
		psel && penable && pwrite |-> pready) else $error("APB write took a wait state");

	// Reads hold one wait state, then complete
	readWaitLow: assert property (@(posedge clk0) disable iff (!arstN)
		psel && !penable && !pwrite |=> !pready) else $error("APB read had no wait state");
	readWaitEnd: assert property (@(posedge clk0) disable iff (!arstN)
		psel && penable && !pwrite && !pready |=> pready) else $error("APB read stalled");

	// ----------------------------------------
	// Line fetch timing
	// ----------------------------------------
	donePulse: assert property (@(posedge clk0) disable iff (!arstN)
		lineDone |=> !lineDone) else $error("lineDone longer than one cycle");
	doneTime: assert property (@(posedge clk0) disable iff (!arstN)
		$past(lineStart && !lineBusy, 34) |-> lineDone) else $error("lineDone late");

endmodule

bind apbVram vidMemAssertions apbChk_i (.clk0(clk0), .arstN(arstN), .psel(psel),
	.penable(penable), .pwrite(pwrite), .pready(pready), .lineStart(1'b0),
	.lineBusy(1'b0), .lineDone(1'b0));

bind lineFetchSeq vidMemAssertions seqChk_i (.clk0(clk0), .arstN(arstN), .psel(1'b0),
	.penable(1'b0), .pwrite(1'b0), .pready(1'b0), .lineStart(lineStart),
	.lineBusy(lineBusy), .lineDone(lineDone));

/* sim/vidMemTb.sv */
// Directed testbench: clock, reset, APB and line tasks, compare tasks and final report
`timescale 1ns/1ps
`include "vid_cfg.svh"

module vidMemTb;
	import vidMemPkg::*;
	import vidCtrlPkg::*;

	localparam int memBytes = 2 ** `VID_BYTE_AW;
	localparam int waitLimit = 8;
	localparam int lineLimit = 100;

	logic clk0;
	logic arstN;
	logic psel, penable, pwrite, pready;
	byteAddr paddr;
	logic [7:0] pwdata, prdata;
	logic lineStart, lineBusy, lineDone;
	logic [$clog2(`VID_ROWS)-1:0] lineRow;
	colIdx colAddr;
	logic colRd;
	lineEntry colData;

	logic [7:0] model [memBytes];
	integer seed;
	int errors;
	int checks;

	vidMemTop dut_i (.*);

	initial begin
		clk0 = 1'b0;
		forever #5 clk0 = ~clk0;
	end

	// ----------------------------------------
	// Compare tasks
	// ----------------------------------------
	task automatic checkByte(input string name, input logic [7:0] got, input logic [7:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("MISMATCH t=%0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic checkEntry(input string name, input lineEntry got, input lineEntry exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("MISMATCH t=%0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic checkFlag(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("MISMATCH t=%0t %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	task automatic abortRun(input string what);
		$display("ERROR t=%0t %s", $time, what);
		$display("*** FAILED ***");
		$finish;
	endtask

	// Hidden tiles read as zero, else palette from attr and the code byte
	function automatic lineEntry expectEntry(input int word);
		lineEntry e;
		logic [7:0] attr;
		attr = model[2 * word + 1];
		e = '0;
		if (!attr[7]) begin
			e.palette = attr[2:0];
			e.code = model[2 * word];
		end
		return e;
	endfunction

	// ----------------------------------------
	// Bus and line tasks
	// ----------------------------------------
	task automatic apbWrite(input int addr, input logic [7:0] data);
		int waits;
		psel = 1'b1;
		pwrite = 1'b1;
		paddr = byteAddr'(addr);
		pwdata = data;
		@(posedge clk0);
		#1;
		penable = 1'b1;
		waits = 0;
		@(negedge clk0);
		while (!pready) begin
			waits++;
			if (waits > waitLimit)
				abortRun("APB write never got pready");
			@(negedge clk0);
		end
		checkFlag("pready on first write access", waits == 0, 1'b1);
		@(posedge clk0);
		#1;
		psel = 1'b0;
		penable = 1'b0;
	endtask

	task automatic apbRead(input int addr, output logic [7:0] data);
		int waits;
		psel = 1'b1;
		pwrite = 1'b0;
		paddr = byteAddr'(addr);
		@(posedge clk0);
		#1;
		penable = 1'b1;
		waits = 0;
		@(negedge clk0);
		while (!pready) begin
			waits++;
			if (waits > waitLimit)
				abortRun("APB read never got pready");
			@(negedge clk0);
		end
		checkFlag("single read wait state", waits == 1, 1'b1);
		data = prdata;
		@(posedge clk0);
		#1;
		psel = 1'b0;
		penable = 1'b0;
	endtask

	// ghostAt gives the cycle of an extra start while busy, -1 for none
	task automatic runLine(input int row, input int ghostAt);
		int cycles;
		lineRow = 5'(row);
		lineStart = 1'b1;
		@(posedge clk0);
		#1;
		lineStart = 1'b0;
		cycles = 0;
		@(negedge clk0);
		checkFlag("lineBusy after lineStart", lineBusy, 1'b1);
		while (!lineDone) begin
			@(posedge clk0);
			#1;
			cycles++;
			lineStart = (cycles == ghostAt);
			lineRow = (cycles == ghostAt) ? 5'(row ^ 7) : 5'(row);
			if (cycles > lineLimit)
				abortRun("lineDone never came after lineStart");
			@(negedge clk0);
		end
		// Visible after edge 33, so the edge that takes it is 34
		checkFlag($sformatf("lineDone on cycle 34, seen on %0d", cycles + 1),
			cycles + 1 == 34, 1'b1);
		checkFlag("lineBusy with lineDone", lineBusy, 1'b1);
		@(posedge clk0);
		#1;
		lineStart = 1'b0;
		lineRow = 5'(row);
		checkFlag("lineDone one cycle wide", lineDone, 1'b0);
		checkFlag("lineBusy low after done", lineBusy, 1'b0);
	endtask

	task automatic readCol(input int c, output lineEntry e);
		colAddr = colIdx'(c);
		colRd = 1'b1;
		@(posedge clk0);
		#1;
		e = colData;
		colRd = 1'b0;
	endtask

	task automatic checkRow(input int row);
		lineEntry e;
		for (int c = 0; c < `VID_COLS; c++) begin
			readCol(c, e);
			checkEntry($sformatf("colData[%0d]", c), e, expectEntry(row * `VID_COLS + c));
		end
		// The first pass cleared every entry
		for (int c = 0; c < `VID_COLS; c++) begin
			readCol(c, e);
			checkEntry($sformatf("colData[%0d] reread", c), e, '0);
		end
	endtask

	// ----------------------------------------
	// Directed tests
	// ----------------------------------------
	task automatic testReset();
		checkFlag("pready after reset", pready, 1'b0);
		checkFlag("lineBusy after reset", lineBusy, 1'b0);
		checkFlag("lineDone after reset", lineDone, 1'b0);
	endtask

	task automatic testApb();
		int addr;
		logic [7:0] data;
		for (int a = 0; a < memBytes; a++) begin
			model[a] = 8'($random(seed));
			apbWrite(a, model[a]);
		end
		for (int i = 0; i < 48; i++) begin
			// Even and odd addresses in turn
			addr = ($random(seed) & (memBytes - 2)) | (i % 2);
			if (i < 16) begin
				model[addr] = 8'($random(seed));
				apbWrite(addr, model[addr]);
			end
			apbRead(addr, data);
			checkByte($sformatf("prdata[%0d]", addr), data, model[addr]);
		end
	endtask

	task automatic testFetch();
		runLine(5, -1);
		checkRow(5);
		runLine(22, -1);
		checkRow(22);
	endtask

	task automatic testBusyStart();
		int extra;
		// Extra start sampled on the edge after the lineDone cycle, FSM already idle
		runLine(9, 33);
		extra = 0;
		for (int i = 0; i < 40; i++) begin
			@(negedge clk0);
			if (lineDone)
				extra++;
		end
		@(posedge clk0);
		#1;
		checkFlag("no lineDone after ignored start", extra == 0, 1'b1);
		checkRow(9);
	endtask

	task automatic testRowUpdate();
		int addr;
		int row;
		for (int r = 0; r < 2; r++) begin
			row = r * (`VID_ROWS - 1);
			runLine(row, -1);
			checkRow(row);
			for (int b = 0; b < 2 * `VID_COLS; b++) begin
				addr = row * 2 * `VID_COLS + b;
				model[addr] = ~model[addr];
				apbWrite(addr, model[addr]);
			end
			runLine(row, -1);
			checkRow(row);
		end
	endtask

	initial begin
		seed = 32'h7b32;
		errors = 0;
		checks = 0;
		arstN = 1'b0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		lineStart = 1'b0;
		lineRow = '0;
		colAddr = '0;
		colRd = 1'b0;
		repeat (2) @(posedge clk0);
		#1;
		arstN = 1'b1;
		testReset();
		testApb();
		testFetch();
		testBusyStart();
		testRowUpdate();
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

/* all.f */
+incdir+rtl
rtl/vidMemPkg.sv
rtl/vidCtrlPkg.sv
rtl/lineBufIf.sv
rtl/apbVram.sv
rtl/lineFetchSeq.sv
rtl/columnCounter.sv
rtl/lineBuffer.sv
rtl/vidMemTop.sv
sim/vidMem_assertions.sv
sim/vidMemTb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f all.f --top-module vidMemTb -o vidMemSim

./obj_dir/vidMemSim | tee sim.log

grep -qF '*** PASSED ***' sim.log
